// File: tests/gc_cases.txt
# name nbytes byte0 byte1 byte2 pad kind  (bytes in hex, unused ones are 00)
# pad is 16 hex digits or random, kind is id, pad or none
identify_first     1 00 00 00 0123456789abcdef id
poll_rumble_on     3 40 03 01 random pad
poll_rumble_off    3 40 03 00 random pad
poll_rumble_again  3 40 03 01 8000ff7f80201040 pad
get_origins        1 41 00 00 random pad
unknown_command    1 55 00 00 random none
poll_bad_second    3 40 02 01 random none
identify_extra     2 00 40 00 random none
identify_again     1 00 00 00 random id
poll_after_reject  3 40 03 01 random pad
unknown_rumbling   1 ff 00 00 random none
poll_all_ones      3 40 03 00 ffffffffffffffff pad
poll_all_zeros     3 40 03 00 0000000000000000 pad
get_origins_again  1 41 00 00 a5a55a5a0f0ff0f0 pad
identify_last      1 00 00 00 random id

// File: filelist.f
+incdir+include
rtl/gc_pkg.sv
rtl/gc_line_io.sv
rtl/gc_serial_rx.sv
rtl/gc_serial_tx.sv
rtl/gc_controller.sv
rtl/gc_emulator_top.sv
tests/gc_controller_assert.sv
tests/gc_emulator_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := gc_emulator_tb
FILELIST := filelist.f
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run $(TOP) with Verilator"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/gc_emulator_tb.sv
//----------------------------------------
// Testbench for gc_emulator_top.
// Cases come from tests/gc_cases.txt, so
// run it from the project root. Stops at
// the first error.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "gc_cfg.svh"

module gc_emulator_tb;
	import gc_pkg::*;

	localparam int q = `GC_QUARTER_CLKS;
	localparam int bit_clks = 4 * q;
	// The reply starts about one idle window after the console stop bit
	localparam int start_limit = 8 * `GC_IDLE_QUARTERS * q;
	localparam int silence_clks = 300;

	logic          clk;
	logic          reset;
	logic          console_low;
	logic          line_wire;
	logic          line_drive_low;
	logic          rumble;
	gc_pad_state_t pad_state;
	// Rumble level the console expects from the requests sent so far
	logic          model_rumble;
	int            case_count;

	// Open-drain wire, released unless someone pulls it low
	assign line_wire = ~(console_low | line_drive_low);

	gc_emulator_top dut0 (
		.clk            (clk),
		.reset          (reset),
		.line_in        (line_wire),
		.pad_state      (pad_state),
		.line_drive_low (line_drive_low),
		.rumble         (rumble)
	);

	always #20 clk = ~clk;

	task automatic abort_test(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_pad(input logic [255:0] name, input gc_pad_state_t exp,
		input gc_pad_state_t act);
		if (act !== exp)
			abort_test($sformatf("MISMATCH %0s pad expected %h actual %h", name, exp, act));
	endtask

	task automatic check_id(input logic [255:0] name, input gc_id_t exp, input gc_id_t act);
		if (act !== exp)
			abort_test($sformatf("MISMATCH %0s id expected %h actual %h", name, exp, act));
	endtask

	task automatic check_rumble(input logic [255:0] name, input logic exp, input logic act);
		if (act !== exp)
			abort_test($sformatf("MISMATCH %0s rumble expected %b actual %b", name, exp, act));
	endtask

	// One console bit, entered and left just after a rising edge
	task automatic drive_bit(input logic b);
		console_low <= 1'b1;
		repeat (b ? q : 3 * q) @(posedge clk);
		console_low <= 1'b0;
		repeat (b ? 3 * q : q) @(posedge clk);
	endtask

	task automatic drive_byte(input logic [7:0] b);
		int i;
		for (i = 7; i >= 0; i--)
			drive_bit(b[i]);
	endtask

	// Stop bit is a single quarter low, then the wire is let go
	task automatic drive_stop();
		console_low <= 1'b1;
		repeat (q) @(posedge clk);
		console_low <= 1'b0;
	endtask

	// The wire is sampled on falling clock edges, away from all drive changes
	task automatic wait_line_fall(input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (line_wire !== 1'b0) begin
			if (n >= limit)
				abort_test($sformatf("Timed out waiting for %s", what));
			n++;
			@(negedge clk);
		end
	endtask

	task automatic measure_low(output int width);
		width = 0;
		while (line_wire === 1'b0) begin
			width++;
			if (width > bit_clks)
				abort_test("Reply pulse stayed low longer than a bit time");
			@(negedge clk);
		end
	endtask

	// Short low pulses are ones and long ones are zeros, MSB first
	task automatic receive_reply(input int nbytes, output logic [63:0] data);
		int width;
		int b;
		data = '0;
		wait_line_fall(start_limit, "the first reply bit");
		for (b = 0; b < nbytes * 8; b++) begin
			if (b != 0)
				wait_line_fall(2 * bit_clks, "the next reply bit");
			measure_low(width);
			data = {data[62:0], (width <= 2 * q) ? 1'b1 : 1'b0};
		end
		wait_line_fall(2 * bit_clks, "the reply stop bit, which never came");
		measure_low(width);
		if (width > 2 * q)
			abort_test("The reply stop bit was a long low pulse");
	endtask

	// A rejected request must leave the wire released for the whole window
	task automatic expect_silence(input logic [255:0] name);
		int n;
		for (n = 0; n < silence_clks; n++) begin
			@(negedge clk);
			if (line_wire !== 1'b1)
				abort_test($sformatf("Case %0s got a reply that should not exist", name));
		end
	endtask

	task automatic run_case(input logic [255:0] name, input int nbytes, input logic [7:0] b0,
		input logic [7:0] b1, input logic [7:0] b2, input gc_pad_state_t pad,
		input logic [255:0] kind);
		logic [63:0] reply;
		@(posedge clk);
		pad_state <= pad;
		drive_byte(b0);
		if (nbytes > 1)
			drive_byte(b1);
		if (nbytes > 2)
			drive_byte(b2);
		drive_stop();
		// A full poll sets rumble from flag bit 0, get origins always clears it
		if (nbytes == 3 && b0 == 8'h40 && b1 == 8'h03)
			model_rumble = b2[0];
		else if (nbytes == 1 && b0 == 8'h41)
			model_rumble = 1'b0;
		if (kind == "id") begin
			receive_reply(3, reply);
			check_id(name, gc_id_t'(`GC_CONTROLLER_ID), gc_id_t'(reply[23:0]));
		end else if (kind == "pad") begin
			receive_reply(8, reply);
			check_pad(name, pad, gc_pad_state_t'(reply));
		end else begin
			expect_silence(name);
		end
		@(negedge clk);
		check_rumble(name, model_rumble, rumble);
		// Let the receiver see the wire idle before the next request
		repeat (4 * `GC_IDLE_QUARTERS * q) @(posedge clk);
	endtask

	initial begin
		int unsigned     seed;
		int              fd;
		int              count;
		int              nbytes;
		logic [1023:0]   line_r;
		logic [255:0]    name_r;
		logic [255:0]    pad_r;
		logic [255:0]    kind_r;
		logic [7:0]      b0;
		logic [7:0]      b1;
		logic [7:0]      b2;
		gc_pad_state_t   pad_val;
		clk = 1'b0;
		reset = 1'b1;
		console_low = 1'b0;
		pad_state = '0;
		model_rumble = 1'b0;
		case_count = 0;
		seed = $urandom(57);
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (line_drive_low !== 1'b0)
			abort_test("The wire is driven low right after reset");
		check_rumble("after_reset", 1'b0, rumble);
		repeat (2) @(posedge clk);

		fd = $fopen("tests/gc_cases.txt", "r");
		if (fd == 0)
			abort_test("Could not open tests/gc_cases.txt");
		line_r = '0;
		while ($fgets(line_r, fd) != 0) begin
			name_r = '0;
			pad_r = '0;
			kind_r = '0;
			count = $sscanf(line_r, "%s %d %h %h %h %s %s", name_r, nbytes, b0, b1, b2,
				pad_r, kind_r);
			// Comment and blank lines never yield all seven columns
			if (count == 7) begin
				if (pad_r == "random")
					pad_val = {$urandom, $urandom};
				else if ($sscanf(pad_r, "%h", pad_val) != 1)
					abort_test($sformatf("Bad pad value in case %0s", name_r));
				run_case(name_r, nbytes, b0, b1, b2, pad_val, kind_r);
				case_count++;
			end
			line_r = '0;
		end
		$fclose(fd);

		if (case_count == 0) begin
			abort_test("No test cases were read from the cases file");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tests/gc_controller_assert.sv
//----------------------------------------
// Protocol checks on gc_controller.
// Bound to every controller instance.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gc_controller_assert (
	input logic                 clk,
	input logic                 reset,
	input gc_pkg::gc_state_t    state,
	input gc_pkg::gc_rx_event_t rx_ev,
	input gc_pkg::gc_tx_req_t   tx_req,
	input logic                 tx_busy,
	input logic                 rumble
);
	import gc_pkg::*;

	// The transmitter would drop a strobe that arrives while it is busy
	strobe_not_busy: assert property (@(posedge clk) disable iff (reset)
		!(tx_req.strobe && tx_busy)) else $error("tx strobe while busy");

	legal_state: assert property (@(posedge clk) disable iff (reset)
		state inside {st_idle, st_rx_cmd_0, st_rx_poll_cmd_1, st_rx_poll_cmd_2,
		st_finish_id, st_finish_poll, st_tx_stopbit, st_tx_id, st_tx_id_wait,
		st_tx_state, st_tx_state_wait}) else $error("illegal controller state");

	// Rumble may only move once a request has ended with a clean stop
	rumble_after_stop: assert property (@(posedge clk) disable iff (reset)
		(rumble != $past(rumble)) |-> $past(rx_ev.stop)) else $error("rumble moved early");

	strobe_single: assert property (@(posedge clk) disable iff (reset)
		!(tx_req.strobe && $past(tx_req.strobe))) else $error("tx strobe held two cycles");

endmodule

bind gc_controller gc_controller_assert assert0 (
	.clk     (clk),
	.reset   (reset),
	.state   (state),
	.rx_ev   (rx_ev),
	.tx_req  (tx_req),
	.tx_busy (tx_busy),
	.rumble  (rumble)
);

`default_nettype wire

// File: rtl/gc_emulator_top.sv
//----------------------------------------
// Single-port controller emulator.
// The wire is split into a sampled input
// and a drive-low output, resolved outside.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gc_emulator_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  line_in,
	input  gc_pkg::gc_pad_state_t pad_state,
	output logic                  line_drive_low,
	output logic                  rumble
);
	import gc_pkg::*;

	logic         line_sync;
	logic         tx_low;
	logic         tx_busy;
	gc_rx_event_t rx_ev;
	gc_tx_req_t   tx_req;

	gc_line_io line_io0 (
		.clk            (clk),
		.reset          (reset),
		.line_in        (line_in),
		.tx_low         (tx_low),
		.line_sync      (line_sync),
		.line_drive_low (line_drive_low)
	);

	// The receiver also hears our own replies, the controller ignores those
	gc_serial_rx rx0 (
		.clk       (clk),
		.reset     (reset),
		.line_sync (line_sync),
		.rx_ev     (rx_ev)
	);

	gc_serial_tx tx0 (
		.clk     (clk),
		.reset   (reset),
		.tx_req  (tx_req),
		.tx_busy (tx_busy),
		.tx_low  (tx_low)
	);

	gc_controller ctrl0 (
		.clk       (clk),
		.reset     (reset),
		.rx_ev     (rx_ev),
		.tx_busy   (tx_busy),
		.pad_state (pad_state),
		.tx_req    (tx_req),
		.rumble    (rumble)
	);

endmodule

`default_nettype wire

// File: rtl/gc_controller.sv
//----------------------------------------
// Request decoder and reply sequencer.
// Handles identify, poll and get origins.
// Get origins answers with live pad data.
// Reply echoes on rx are ignored.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "gc_cfg.svh"

module gc_controller (
	input  logic                  clk,
	input  logic                  reset,
	input  gc_pkg::gc_rx_event_t  rx_ev,
	input  logic                  tx_busy,
	input  gc_pkg::gc_pad_state_t pad_state,
	output gc_pkg::gc_tx_req_t    tx_req,
	output logic                  rumble
);
	import gc_pkg::*;

	localparam gc_id_t ctrl_id = `GC_CONTROLLER_ID;

	gc_state_t   state;
	logic [7:0]  poll_flags;
	logic [3:0]  byte_cnt;
	logic        tx_strobe;
	logic        tx_stopbit;
	logic [7:0]  tx_data;
	logic [63:0] reply_sh;
	logic        rx_abort;
	logic        rx_any;
	logic        load_id;
	logic        load_pad;
	logic        send_byte;

	// Anything except a stop is fatal once the request bytes are complete
	assign rx_abort = rx_ev.start | rx_ev.error | rx_ev.strobe;

	// While bytes are still expected, only a strobe is welcome
	assign rx_any = rx_ev.start | rx_ev.error | rx_ev.stop;

	assign load_id = state == st_finish_id && rx_ev.stop && !rx_abort;
	assign load_pad = state == st_finish_poll && rx_ev.stop && !rx_abort;
	assign send_byte = (state == st_tx_id || state == st_tx_state) && !tx_busy;

	assign tx_req = '{strobe: tx_strobe, stopbit: tx_stopbit, data: tx_data};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			poll_flags <= '0;
			byte_cnt <= '0;
			tx_strobe <= 1'b0;
			tx_stopbit <= 1'b0;
			rumble <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					// Stray stop or error events from our own reply land here
					tx_strobe <= 1'b0;
					tx_stopbit <= 1'b0;
					byte_cnt <= '0;
					if (rx_ev.start)
						state <= st_rx_cmd_0;
				end

				st_rx_cmd_0: begin
					if (rx_any) begin
						state <= st_idle;
					end else if (rx_ev.strobe) begin
						case (rx_ev.data)
							8'h00: state <= st_finish_id;
							8'h40: state <= st_rx_poll_cmd_1;
							8'h41: begin
								// Get origins always turns the motor off
								poll_flags <= 8'h00;
								state <= st_finish_poll;
							end
							default: state <= st_idle;
						endcase
					end
				end

				st_rx_poll_cmd_1: begin
					if (rx_any)
						state <= st_idle;
					else if (rx_ev.strobe)
						state <= (rx_ev.data == 8'h03) ? st_rx_poll_cmd_2 : st_idle;
				end

				st_rx_poll_cmd_2: begin
					// The third byte is a flag field and is taken as it is
					if (rx_any) begin
						state <= st_idle;
					end else if (rx_ev.strobe) begin
						poll_flags <= rx_ev.data;
						state <= st_finish_poll;
					end
				end

				st_finish_id: begin
					if (rx_abort)
						state <= st_idle;
					else if (rx_ev.stop)
						state <= st_tx_id;
				end

				st_finish_poll: begin
					// Rumble is committed only once the request ended cleanly
					if (rx_abort) begin
						state <= st_idle;
					end else if (rx_ev.stop) begin
						rumble <= poll_flags[0];
						state <= st_tx_state;
					end
				end

				st_tx_stopbit: begin
					if (!tx_busy) begin
						tx_stopbit <= 1'b1;
						tx_strobe <= 1'b1;
						state <= st_idle;
					end
				end

				st_tx_id: begin
					if (!tx_busy) begin
						tx_stopbit <= 1'b0;
						tx_strobe <= 1'b1;
						byte_cnt <= byte_cnt + 4'd1;
						state <= st_tx_id_wait;
					end
				end

				st_tx_id_wait: begin
					// Gives the transmitter one cycle to raise busy
					tx_strobe <= 1'b0;
					state <= (byte_cnt == 4'd3) ? st_tx_stopbit : st_tx_id;
				end

				st_tx_state: begin
					if (!tx_busy) begin
						tx_stopbit <= 1'b0;
						tx_strobe <= 1'b1;
						byte_cnt <= byte_cnt + 4'd1;
						state <= st_tx_state_wait;
					end
				end

				st_tx_state_wait: begin
					tx_strobe <= 1'b0;
					state <= (byte_cnt == 4'd8) ? st_tx_stopbit : st_tx_state;
				end

				default: state <= st_idle;
			endcase
		end
	end

	// One reply register for both answers, the ID sits in the top three bytes
	always_ff @(posedge clk) begin
		if (load_id) begin
			reply_sh <= {ctrl_id, 40'h0};
		end else if (load_pad) begin
			reply_sh <= pad_state;
		end else if (send_byte) begin
			tx_data <= reply_sh[63:56];
			reply_sh <= {reply_sh[55:0], 8'h00};
		end
	end

endmodule

`default_nettype wire

// File: rtl/gc_serial_tx.sv
//----------------------------------------
// Pulse-width bit transmitter, MSB first.
// A byte is busy for 32 quarters and a
// stop bit for 2. Requests while busy are
// dropped.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "gc_cfg.svh"

module gc_serial_tx (
	input  logic               clk,
	input  logic               reset,
	input  gc_pkg::gc_tx_req_t tx_req,
	output logic               tx_busy,
	output logic               tx_low
);

	localparam int quarter_clks = `GC_QUARTER_CLKS;
	localparam int pre_w = $clog2(quarter_clks);
	localparam logic [pre_w-1:0] pre_last = pre_w'(quarter_clks - 1);

	logic             accept;
	logic             quarter_end;
	logic             bit_end;
	logic             cur_bit;
	logic [pre_w-1:0] pre;
	logic [1:0]       qidx;
	logic [2:0]       bit_cnt;
	logic             stop_mode;
	logic [7:0]       shreg;

	assign accept = tx_req.strobe && !tx_busy;
	assign quarter_end = tx_busy && pre == pre_last;

	// Data bits are four quarters long, the stop bit only two
	assign bit_end = quarter_end && (stop_mode ? qidx == 2'd1 : qidx == 2'd3);

	// The stop bit is shaped like a 1 bit that is cut short
	assign cur_bit = stop_mode | shreg[7];

	// First quarter always low, the middle two only for a 0, the last always high
	assign tx_low = tx_busy && (qidx == 2'd0 || (!cur_bit && qidx != 2'd3));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_busy <= 1'b0;
			pre <= '0;
			qidx <= '0;
			bit_cnt <= '0;
			stop_mode <= 1'b0;
		end else if (accept) begin
			tx_busy <= 1'b1;
			pre <= '0;
			qidx <= '0;
			bit_cnt <= '0;
			stop_mode <= tx_req.stopbit;
		end else if (quarter_end) begin
			pre <= '0;
			if (bit_end) begin
				// Busy drops right after the final quarter
				if (stop_mode || bit_cnt == 3'd7) begin
					tx_busy <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 3'd1;
					qidx <= '0;
				end
			end else begin
				qidx <= qidx + 2'd1;
			end
		end else if (tx_busy) begin
			pre <= pre + 1'b1;
		end
	end

	// Outgoing byte, bit 7 is the one on the wire
	always_ff @(posedge clk) begin
		if (accept)
			shreg <= tx_req.data;
		else if (bit_end && !stop_mode)
			shreg <= {shreg[6:0], 1'b0};
	end

endmodule

`default_nettype wire

// File: rtl/gc_serial_rx.sv
//----------------------------------------
// Pulse-width bit receiver, MSB first.
// Expects line_sync already synchronized.
// A lone trailing 1 bit is the stop bit.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "gc_cfg.svh"

module gc_serial_rx (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 line_sync,
	output gc_pkg::gc_rx_event_t rx_ev
);

	localparam int quarter_clks = `GC_QUARTER_CLKS;
	localparam int idle_quarters = `GC_IDLE_QUARTERS;
	localparam int pre_w = $clog2(quarter_clks);
	localparam int high_w = $clog2(idle_quarters + 1);
	localparam logic [pre_w-1:0] pre_last = pre_w'(quarter_clks - 1);
	localparam logic [pre_w-1:0] pre_half = pre_w'(quarter_clks / 2);
	localparam logic [high_w-1:0] high_last = high_w'(idle_quarters - 1);
	localparam logic [high_w-1:0] high_sat = high_w'(idle_quarters);

	logic              line_prev;
	logic              fall;
	logic [pre_w-1:0]  fall_pre;
	logic [2:0]        fall_q;
	logic [pre_w-1:0]  high_pre;
	logic [high_w-1:0] high_q;
	logic              active;
	logic              bit_pending;
	logic              last_bit;
	logic [2:0]        bit_cnt;
	logic [6:0]        shreg;
	logic              sample_now;
	logic              low_timeout;
	logic              idle_timeout;

	assign fall = line_prev & ~line_sync;

	// Bits are read two quarters after their falling edge
	assign sample_now = bit_pending && !fall && fall_q == 3'd2 && fall_pre == '0;

	// A 0 bit is three quarters low, so half a quarter more is a fault
	assign low_timeout = active && !fall && !line_sync && fall_q == 3'd3 &&
		fall_pre == pre_half;

	// Fires once as the high counter reaches its saturation value
	assign idle_timeout = active && line_sync && high_q == high_last && high_pre == pre_last;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			line_prev <= 1'b1;
			fall_pre <= '0;
			fall_q <= 3'd4;
			high_pre <= '0;
			high_q <= '0;
			active <= 1'b0;
			bit_pending <= 1'b0;
			last_bit <= 1'b0;
			bit_cnt <= '0;
			rx_ev <= '0;
		end else begin
			line_prev <= line_sync;
			rx_ev.start <= 1'b0;
			rx_ev.stop <= 1'b0;
			rx_ev.error <= 1'b0;
			rx_ev.strobe <= 1'b0;

			// Quarters since the last falling edge saturate at four
			if (fall) begin
				fall_pre <= '0;
				fall_q <= '0;
			end else if (fall_q != 3'd4) begin
				if (fall_pre == pre_last) begin
					fall_pre <= '0;
					fall_q <= fall_q + 3'd1;
				end else begin
					fall_pre <= fall_pre + 1'b1;
				end
			end

			// Quarters of unbroken high level restart whenever the line is low
			if (!line_sync) begin
				high_pre <= '0;
				high_q <= '0;
			end else if (high_q != high_sat) begin
				if (high_pre == pre_last) begin
					high_pre <= '0;
					high_q <= high_q + 1'b1;
				end else begin
					high_pre <= high_pre + 1'b1;
				end
			end

			// Every falling edge opens a bit and the first one after idle opens a message
			if (fall) begin
				bit_pending <= 1'b1;
				if (!active) begin
					active <= 1'b1;
					bit_cnt <= '0;
					rx_ev.start <= 1'b1;
				end
			end

			if (sample_now) begin
				bit_pending <= 1'b0;
				last_bit <= line_sync;
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					rx_ev.strobe <= 1'b1;
					rx_ev.data <= {shreg, line_sync};
				end
			end

			// A message ends on exactly one of stop or error
			if (low_timeout) begin
				active <= 1'b0;
				rx_ev.error <= 1'b1;
			end else if (idle_timeout) begin
				active <= 1'b0;
				if (last_bit && bit_cnt == 3'd1 && !bit_pending)
					rx_ev.stop <= 1'b1;
				else
					rx_ev.error <= 1'b1;
			end
		end
	end

	// Holds the seven bits received before the one being sampled
	always_ff @(posedge clk) begin
		if (sample_now)
			shreg <= {shreg[5:0], line_sync};
	end

endmodule

`default_nettype wire

// File: rtl/gc_line_io.sv
//----------------------------------------
// Pin side of the open-drain data line.
// The sampled level lags by two cycles and
// the drive by one.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gc_line_io (
	input  logic clk,
	input  logic reset,
	input  logic line_in,
	input  logic tx_low,
	output logic line_sync,
	output logic line_drive_low
);

	// First synchronizer stage, may go metastable
	logic line_meta;

	// Both stages come out of reset as a released, high line
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			line_meta <= 1'b1;
			line_sync <= 1'b1;
		end else begin
			line_meta <= line_in;
			line_sync <= line_meta;
		end
	end

	// The pin driver is a flop so that decode glitches never reach the wire
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			line_drive_low <= 1'b0;
		end else begin
			line_drive_low <= tx_low;
		end
	end

endmodule

`default_nettype wire

// File: rtl/gc_pkg.sv
//----------------------------------------
// Types shared by the controller emulator.
// The pad state goes out MSB first, so the
// field order here is the wire order.
//----------------------------------------
`default_nettype none

package gc_pkg;

	// Pad state as the host supplies it, 64 bits
	typedef struct packed {
		logic [15:0] buttons;
		logic [7:0]  stick_x;
		logic [7:0]  stick_y;
		logic [7:0]  cstick_x;
		logic [7:0]  cstick_y;
		logic [7:0]  trig_l;
		logic [7:0]  trig_r;
	} gc_pad_state_t;

	// Controller ID answered to the identify command
	typedef struct packed {
		logic [15:0] dev_type;
		logic [7:0]  dev_status;
	} gc_id_t;

	// Receiver events, each flag is a single-cycle pulse
	typedef struct packed {
		logic       start;
		logic       stop;
		logic       error;
		logic       strobe;
		logic [7:0] data;
	} gc_rx_event_t;

	// Transmit request, only taken while the transmitter is not busy
	typedef struct packed {
		logic       strobe;
		logic       stopbit;
		logic [7:0] data;
	} gc_tx_req_t;

	// States of the request decoder and response sequencer
	typedef enum logic [3:0] {
		st_idle,
		st_rx_cmd_0,
		st_rx_poll_cmd_1,
		st_rx_poll_cmd_2,
		st_finish_id,
		st_finish_poll,
		st_tx_stopbit,
		st_tx_id,
		st_tx_id_wait,
		st_tx_state,
		st_tx_state_wait
	} gc_state_t;

endpackage

`default_nettype wire

// File: include/gc_cfg.svh
//----------------------------------------
// Line timing and controller identity.
// GC_QUARTER_CLKS must be 2 or more.
// GC_IDLE_QUARTERS must stay below 16.
//----------------------------------------
`ifndef GC_CFG_SVH
`define GC_CFG_SVH

// Clock cycles in one quarter of a bit time on the wire
`define GC_QUARTER_CLKS 4

// High quarters after line activity that close a message
`define GC_IDLE_QUARTERS 6

// ID answered to the identify request, as a standard pad reports it
`define GC_CONTROLLER_ID 24'h090020

`endif
